// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing
LINTFLAGS = --lint-only --timing
TOP       = zmips_tb
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/zmips_config.svh
`ifndef ZMIPS_CONFIG_SVH
`define ZMIPS_CONFIG_SVH

// Core widths
`define ZMIPS_XLEN      32  // Data and address width
`define ZMIPS_REG_AW    5   // Register address width
`define ZMIPS_IMM_W     26  // I-format immediate field

// Fetch
`define ZMIPS_PC_STEP   4   // Bytes per instruction
`define ZMIPS_RESET_PC  0   // First fetch address

`endif

// File: common/zmips_isa_pkg.sv
`include "zmips_config.svh"

package zmips_isa_pkg;

    // Instruction format from bits 31:30
    typedef enum logic [1:0] {
        FMT_R    = 2'b00,   // Plain R-format
        FMT_R_LI = 2'b01,   // R space, op bit 4 set means load immediate
        FMT_I    = 2'b10,   // Relative branch
        FMT_J    = 2'b11    // Absolute jump
    } fmt_e;

    // Bit 3 is the shift select, bits 2:0 come from funct[5:3]
    typedef enum logic [3:0] {
        ALU_AND  = 4'b0000,
        ALU_OR   = 4'b0001,
        ALU_XOR  = 4'b0010,
        ALU_PASS = 4'b0011, // Operand b straight through
        ALU_ADD  = 4'b0100,
        ALU_SUB  = 4'b0101,
        ALU_SLL  = 4'b1000,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } alu_op_e;

    typedef enum logic [1:0] {COND_Z, COND_C, COND_N, COND_ALWAYS} cond_e;

    typedef struct packed {
        logic [5:0]               op;
        logic [`ZMIPS_REG_AW-1:0] rs;
        logic [`ZMIPS_REG_AW-1:0] rt;
        logic [`ZMIPS_REG_AW-1:0] rd;
        logic [4:0]               shamt;
        logic [5:0]               funct; // 5:3 ALU op, 2:0 flag enables Z C N
    } r_fmt_t;

    typedef struct packed {
        logic [3:0]              op;  // Bit 1 picks flag polarity on branches
        logic [1:0]              cc;
        logic [`ZMIPS_IMM_W-1:0] imm;
    } i_fmt_t;

    typedef struct packed {
        logic [1:0]              op;
        logic [`ZMIPS_XLEN-3:0]  addr; // Word address
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        j_fmt_t j;
    } instr_t;

endpackage

// File: common/zmips_pipe_pkg.sv
`include "zmips_config.svh"

package zmips_pipe_pkg;

    // Decoded control for one instruction
    typedef struct packed {
        zmips_isa_pkg::alu_op_e alu_op;
        logic imm_sel;  // Immediate replaces operand b
        logic mem_rd;
        logic mem_wr;
        logic wr_reg;
        logic wr_z;
        logic wr_c;
        logic wr_n;
    } id_ctrl_t;

    typedef struct packed {
        id_ctrl_t                 ctrl;
        logic [`ZMIPS_XLEN-1:0]   rs_val;
        logic [`ZMIPS_XLEN-1:0]   rt_val;
        logic [`ZMIPS_REG_AW-1:0] rs;
        logic [`ZMIPS_REG_AW-1:0] rt;
        logic [`ZMIPS_REG_AW-1:0] rd;
        logic [`ZMIPS_XLEN-1:0]   imm_se;
        logic [4:0]               shamt;
    } id_ex_t;

    typedef struct packed {
        logic [`ZMIPS_XLEN-1:0]   alu_rslt; // Also the memory address
        logic [`ZMIPS_XLEN-1:0]   st_data;
        logic [`ZMIPS_REG_AW-1:0] wb_reg;
        logic mem_rd;
        logic mem_wr;
        logic wr_reg;
    } ex_mem_t;

    typedef struct packed {
        logic [`ZMIPS_XLEN-1:0]   mem_data;
        logic [`ZMIPS_XLEN-1:0]   alu_data;
        logic [`ZMIPS_REG_AW-1:0] wb_reg;
        logic mem_rd;
        logic wr_reg;
    } mem_wb_t;

    typedef struct packed {
        logic z;
        logic c;
        logic n;
    } flags_t;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_e;

    typedef enum logic [1:0] {REDIR_NONE, REDIR_BRANCH, REDIR_JUMP} redirect_e;

endpackage

// File: dv/zmips_tb.sv
`timescale 1ns/100ps

module zmips_tb;

    localparam int          NUM_TESTS = 6;
    localparam int          ROM_DEPTH = 256;
    localparam int          RUN_LIMIT = 200;            // Cycles per program
    localparam logic [31:0] END_ADDR  = 32'h0000_03fc;  // Final store of every program
    localparam logic [2:0]  F_AND     = 3'b000;
    localparam logic [2:0]  F_OR      = 3'b001;
    localparam logic [2:0]  F_XOR     = 3'b010;
    localparam logic [2:0]  F_ADD     = 3'b100;
    localparam logic [2:0]  F_SUB     = 3'b101;
    localparam logic [2:0]  F_SLL     = 3'b000;
    localparam logic [2:0]  F_SRL     = 3'b010;
    localparam logic [2:0]  F_SRA     = 3'b011;

    logic                  clk;
    logic                  rst;
    logic                  rst_req = 1'b0;
    logic [31:0]           i_addr;
    zmips_isa_pkg::instr_t i_data;
    logic [31:0]           d_addr;
    logic [31:0]           d_wdata;
    logic [31:0]           d_rdata;
    logic                  d_rd;
    logic                  d_wr;

    logic [31:0] rom [ROM_DEPTH] = '{default: '0};  // Word addressed
    logic [31:0] ram [ROM_DEPTH] = '{default: '0};
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] next_addr;     // Address of the next expected store
    logic        done = 1'b0;
    int          errors = 0;
    int          pc_w = 0;      // Next ROM word to fill
    int          seed = 74;

    zmips_tb_clk clk0 (.rst_req(rst_req), .clk(clk), .rst(rst));

    zmips_top dut0 (.clk(clk), .rst(rst), .i_addr(i_addr), .i_data(i_data),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_rdata(d_rdata), .d_rd(d_rd), .d_wr(d_wr));

    assign i_data  = rom[i_addr[9:2]];
    assign d_rdata = ram[d_addr[9:2]];  // Same-cycle read

    // RAM write and store log
    always @(posedge clk)
    begin
        if (rst)
        begin
            done = 1'b0;
            log_addr.delete();
            log_data.delete();
            for (int i = 0; i < ROM_DEPTH; i++)
                ram[8'(i)] <= '0;
        end
        else if (d_wr)
        begin
            ram[d_addr[9:2]] <= d_wdata;
            if (d_addr == END_ADDR)
                done = 1'b1;
            else
            begin
                log_addr.push_back(d_addr);
                log_data.push_back(d_wdata);
            end
        end
    end

    function automatic logic [31:0] pack_r(input logic [5:0] op, input int rs, input int rt,
        input int rd, input int shamt, input logic [5:0] funct);
        return {op, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), funct};
    endfunction

    function automatic logic [31:0] alu_cmd(input logic [2:0] fn, input int rd, input int rs,
        input int rt, input logic [2:0] fl);
        return pack_r(6'b000100, rs, rt, rd, 0, {fn, fl});     // fl enables Z C N
    endfunction

    function automatic logic [31:0] shift_cmd(input logic [2:0] fn, input int rd, input int rs,
        input int sh);
        return pack_r(6'b000101, rs, 0, rd, sh, {fn, 3'b000});
    endfunction

    // Address is rs passed through SLL by 0
    function automatic logic [31:0] store_cmd(input int ra, input int data_reg);
        return pack_r(6'b001001, ra, data_reg, 0, 0, 6'b000000);
    endfunction

    function automatic logic [31:0] load_cmd(input int rd, input int ra);
        return pack_r(6'b001101, ra, 0, rd, 0, 6'b000000);
    endfunction

    function automatic logic [31:0] load_imm(input logic [25:0] imm);
        return {4'b0100, 2'b00, imm};   // Into r0
    endfunction

    function automatic logic [31:0] branch_cmd(input int set, input int cc, input int off);
        return {2'b10, 1'(set), 1'b0, 2'(cc), 26'(off)};
    endfunction

    function automatic logic [31:0] jump_cmd(input int word);
        return {2'b11, 30'(word)};
    endfunction

    // Result with carry on top, carry on SUB means a >= b
    function automatic logic [32:0] alu_model(input logic [2:0] fn, input logic [31:0] a,
        input logic [31:0] b);
        case (fn)
            F_AND:   return {1'b0, a & b};
            F_OR:    return {1'b0, a | b};
            F_XOR:   return {1'b0, a ^ b};
            F_ADD:   return {1'b0, a} + {1'b0, b};
            F_SUB:   return {a >= b, a - b};
            default: return {1'b0, b};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic emit(input logic [31:0] instr);
        rom[8'(pc_w)] = instr;
        pc_w++;
    endtask

    // Builds a 32-bit value through r0 in two halves
    task automatic load_const(input int rd, input logic [31:0] v);
        emit(load_imm({10'b0, v[31:16]}));
        emit(alu_cmd(F_OR, rd, 0, 0, 3'b000));
        emit(shift_cmd(F_SLL, rd, rd, 16));
        emit(load_imm({10'b0, v[15:0]}));
        emit(alu_cmd(F_OR, rd, rd, 0, 3'b000));
    endtask

    // Store at r30 then step r30 by r29
    task automatic store_next(input int data_reg, input logic [31:0] value, input logic logged);
        emit(store_cmd(30, data_reg));
        emit(alu_cmd(F_ADD, 30, 30, 29, 3'b000));
        if (logged)
        begin
            exp_addr.push_back(next_addr);
            exp_data.push_back(value);
            next_addr += 32'd4;
        end
    endtask

    task automatic start_test();
        @(posedge clk);
        rst_req <= 1'b1;
        @(posedge clk);
        rst_req <= 1'b0;
        #1;
        for (int i = 0; i < ROM_DEPTH; i++)
            rom[8'(i)] = '0;                // NOP fill
        exp_addr.delete();
        exp_data.delete();
        pc_w = 0;
        load_const(29, 32'd4);
        load_const(30, 32'h0000_0100);
        next_addr = 32'h0000_0100;
    endtask

    task automatic compare_log(input string name);
        check_value({name, " store count"}, 32'(log_addr.size()), 32'(exp_addr.size()));
        for (int i = 0; i < exp_addr.size() && i < log_addr.size(); i++)
        begin
            check_value("d_addr", log_addr[i], exp_addr[i]);
            check_value("d_wdata", log_data[i], exp_data[i]);
        end
    endtask

    // Appends the end store, releases reset and waits for that store
    task automatic run_program(input string name);
        int n;
        int q;
        load_const(31, END_ADDR);
        emit(store_cmd(31, 0));
        q = pc_w;
        emit(jump_cmd(q));                  // Spin in place
        do
        begin
            @(posedge clk);
            #1;
        end
        while (rst);
        check_value("i_addr", i_addr, 32'h0);
        check_value("d_rd", {31'b0, d_rd}, 32'h0);
        check_value("d_wr", {31'b0, d_wr}, 32'h0);
        n = 0;
        while (!done && n < RUN_LIMIT)
        begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!done)
        begin
            errors++;
            $display("%s: program never reached its final store", name);
        end
        compare_log(name);
    endtask

    task automatic reset_test();
        start_test();
        run_program("reset");
    endtask

    task automatic alu_chain_test();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] e3;
        logic [31:0] e4;
        logic [31:0] e5;
        logic [31:0] e6;
        logic [31:0] e7;
        a  = $random(seed);
        b  = $random(seed);
        e3 = 32'(alu_model(F_AND, a, b));
        e4 = 32'(alu_model(F_OR, e3, a));
        e5 = 32'(alu_model(F_XOR, e4, b));
        e6 = 32'(alu_model(F_ADD, e4, e5));
        e7 = 32'(alu_model(F_SUB, e6, a));
        start_test();
        load_const(1, a);
        load_const(2, b);
        emit(alu_cmd(F_AND, 3, 1, 2, 3'b000));
        emit(alu_cmd(F_OR, 4, 3, 1, 3'b000));  // r3 from MEM
        emit(alu_cmd(F_XOR, 5, 4, 2, 3'b000));
        emit(alu_cmd(F_ADD, 6, 4, 5, 3'b000));  // r4 from WB
        emit(alu_cmd(F_SUB, 7, 6, 1, 3'b000));
        store_next(3, e3, 1'b1);
        store_next(4, e4, 1'b1);
        store_next(5, e5, 1'b1);
        store_next(6, e6, 1'b1);
        store_next(7, e7, 1'b1);
        run_program("ALU chain");
    endtask

    task automatic shift_test();
        logic [31:0] a;
        int          shamts [3] = '{1, 7, 31};
        a = $random(seed);
        a = a | 32'h8000_0000;              // Sign bit set for SRA
        start_test();
        load_const(1, a);
        for (int k = 0; k < 3; k++)
        begin
            emit(shift_cmd(F_SLL, 2, 1, shamts[k]));
            store_next(2, a << shamts[k], 1'b1);
            emit(shift_cmd(F_SRL, 2, 1, shamts[k]));
            store_next(2, a >> shamts[k], 1'b1);
            emit(shift_cmd(F_SRA, 2, 1, shamts[k]));
            // Sign bit fills the vacated top bits
            store_next(2, (a >> shamts[k]) | ~(32'hffff_ffff >> shamts[k]), 1'b1);
        end
        run_program("shift");
    endtask

    task automatic load_use_test();
        logic [31:0] a;
        a = $random(seed);
        start_test();
        load_const(1, a);
        emit(alu_cmd(F_OR, 28, 30, 30, 3'b000));   // Keep the store address
        store_next(1, a, 1'b1);
        emit(load_cmd(2, 28));
        emit(alu_cmd(F_ADD, 3, 2, 1, 3'b000));     // Stall on rs
        store_next(3, a + a, 1'b1);
        emit(load_cmd(5, 28));
        emit(alu_cmd(F_XOR, 6, 1, 5, 3'b000));     // Stall on rt
        store_next(6, 32'h0, 1'b1);
        run_program("load use");
    endtask

    // Flag setter, branch past the marker store, flushed slot
    task automatic branch_case(input logic [2:0] fn, input int rs, input int rt,
        input logic [31:0] a, input logic [31:0] b, input int cc, input int set,
        input logic [31:0] marker);
        logic [32:0] r;
        logic [2:0]  en;
        logic        flag;
        logic        taken;
        r = alu_model(fn, a, b);
        case (cc)
            0:
            begin
                flag = r[31:0] == 32'h0;
                en   = 3'b100;
            end
            1:
            begin
                flag = r[32];
                en   = 3'b010;
            end
            2:
            begin
                flag = r[31];
                en   = 3'b001;
            end
            default:
            begin
                flag = 1'b0;
                en   = 3'b000;
            end
        endcase
        taken = cc == 3 || flag == set[0];
        emit(alu_cmd(fn, 3, rs, rt, en));
        emit(branch_cmd(set, cc, 3));       // Target skips st and add
        emit(store_cmd(30, 9));             // Flushed slot
        store_next(10, marker, !taken);
    endtask

    task automatic branch_test();
        logic [31:0] marker;
        marker = $random(seed);
        start_test();
        load_const(12, 32'h1);
        load_const(13, 32'hffff_ffff);
        load_const(10, marker);
        load_const(9, 32'hbad0_0bad);
        branch_case(F_SUB, 12, 12, 32'h1, 32'h1, 0, 1, marker);
        branch_case(F_SUB, 12, 12, 32'h1, 32'h1, 0, 0, marker);
        branch_case(F_ADD, 13, 12, 32'hffff_ffff, 32'h1, 1, 1, marker);
        branch_case(F_ADD, 12, 12, 32'h1, 32'h1, 1, 1, marker);
        branch_case(F_OR, 13, 13, 32'hffff_ffff, 32'hffff_ffff, 2, 0, marker);
        branch_case(F_OR, 12, 12, 32'h1, 32'h1, 2, 0, marker);
        branch_case(F_SUB, 12, 13, 32'h1, 32'hffff_ffff, 1, 0, marker);
        branch_case(F_OR, 12, 12, 32'h1, 32'h1, 3, 0, marker);
        run_program("branch");
    endtask

    task automatic jump_test();
        logic [31:0] marker;
        int          p;
        marker = $random(seed);
        start_test();
        load_const(10, marker);
        p = pc_w;
        emit(jump_cmd(p + 4));
        emit(store_cmd(30, 9));             // Flushed
        emit(store_cmd(30, 9));             // Jumped over
        emit(store_cmd(30, 9));
        store_next(10, marker, 1'b1);
        run_program("jump");
    endtask

    // Limit covers every test at one ROM depth of cycles
    initial
    begin
        #(NUM_TESTS * ROM_DEPTH * 100);
        $display("Timeout: simulation ran past its time limit");
        $display("tests failed");
        $finish;
    end

    initial
    begin
        reset_test();
        alu_chain_test();
        shift_test();
        load_use_test();
        branch_test();
        jump_test();
        $display("Tests run: %0d, errors: %0d", NUM_TESTS, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: dv/zmips_tb_clk.sv
`timescale 1ns/100ps

module zmips_tb_clk (
    input  logic rst_req,   // Restarts the reset pulse
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD = 50;
    localparam int RST_CYCLES  = 5;

    logic [2:0] rst_cnt = 3'(RST_CYCLES);   // Reset also runs at time 0

    initial
    begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk)
    begin
        if (rst_req)
            rst_cnt <= 3'(RST_CYCLES);
        else if (rst_cnt != 3'd0)
            rst_cnt <= rst_cnt - 3'd1;
    end

    assign rst = rst_cnt != 3'd0;   // High for five rising edges

endmodule

// File: hw/execute/zmips_alu.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_alu (
    input  logic [`ZMIPS_XLEN-1:0] a,
    input  logic [`ZMIPS_XLEN-1:0] b,
    input  zmips_isa_pkg::alu_op_e op,
    input  logic [4:0]             shamt,
    output logic [`ZMIPS_XLEN-1:0] y,
    output logic                   zero,
    output logic                   cout
);

    logic                 sub;
    logic [`ZMIPS_XLEN:0] sum;      // Extra bit is the carry out

    // SUB as a + ~b + 1, so carry out means no borrow
    assign sub = op == zmips_isa_pkg::ALU_SUB;
    assign sum = {1'b0, a} + {1'b0, sub ? ~b : b} + (`ZMIPS_XLEN+1)'(sub);

    always_comb
    begin
        cout = 1'b0;                // Logic and shifts leave C clear
        case (op)
            zmips_isa_pkg::ALU_AND: y = a & b;
            zmips_isa_pkg::ALU_OR:  y = a | b;
            zmips_isa_pkg::ALU_XOR: y = a ^ b;
            zmips_isa_pkg::ALU_ADD,
            zmips_isa_pkg::ALU_SUB:
            begin
                y    = sum[`ZMIPS_XLEN-1:0];
                cout = sum[`ZMIPS_XLEN];
            end
            zmips_isa_pkg::ALU_SLL: y = a << shamt;
            zmips_isa_pkg::ALU_SRL: y = a >> shamt;
            zmips_isa_pkg::ALU_SRA: y = $signed(a) >>> shamt;
            default:                y = b;  // PASS and unused codes
        endcase
    end

    assign zero = y == '0;

endmodule

// File: hw/execute/zmips_execute.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  zmips_pipe_pkg::id_ctrl_t ctrl,
    input  logic                     bubble,
    input  zmips_pipe_pkg::fwd_sel_e rs_sel,
    input  zmips_pipe_pkg::fwd_sel_e rt_sel,
    input  zmips_isa_pkg::instr_t    ir,
    input  logic [`ZMIPS_XLEN-1:0]   rs_val,
    input  logic [`ZMIPS_XLEN-1:0]   rt_val,
    input  logic [`ZMIPS_XLEN-1:0]   wb_data,
    output zmips_pipe_pkg::id_ex_t   id_ex,
    output zmips_pipe_pkg::ex_mem_t  ex_mem,
    output zmips_pipe_pkg::flags_t   flags  // Next flag values, forwarded to ID
);

    logic [`ZMIPS_XLEN-1:0] op_a, fwd_b, op_b, alu_y;
    logic                   alu_zero, alu_cout;
    zmips_pipe_pkg::flags_t flag_q;

    function automatic logic [`ZMIPS_XLEN-1:0] fwd_mux(
        input zmips_pipe_pkg::fwd_sel_e sel,
        input logic [`ZMIPS_XLEN-1:0]   reg_val, mem_val, wb_val
    );
        case (sel)
            zmips_pipe_pkg::FWD_MEM: return mem_val;
            zmips_pipe_pkg::FWD_WB:  return wb_val;
            default:                 return reg_val;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        id_ex.rs_val <= rs_val;
        id_ex.rt_val <= rt_val;
        id_ex.rs     <= ir.r.rs;
        id_ex.rt     <= ir.r.rt;
        id_ex.rd     <= ctrl.imm_sel ? '0 : ir.r.rd;   // Load immediate targets r0
        id_ex.imm_se <= {{(`ZMIPS_XLEN-`ZMIPS_IMM_W){ir.i.imm[`ZMIPS_IMM_W-1]}}, ir.i.imm};
        id_ex.shamt  <= ir.r.shamt;
        id_ex.ctrl   <= (rst || bubble) ? '0 : ctrl;
    end

    assign op_a  = fwd_mux(rs_sel, id_ex.rs_val, ex_mem.alu_rslt, wb_data);
    assign fwd_b = fwd_mux(rt_sel, id_ex.rt_val, ex_mem.alu_rslt, wb_data);
    assign op_b  = id_ex.ctrl.imm_sel ? id_ex.imm_se : fwd_b;

    zmips_alu alu0 (.a(op_a), .b(op_b), .op(id_ex.ctrl.alu_op), .shamt(id_ex.shamt),
        .y(alu_y), .zero(alu_zero), .cout(alu_cout));

    // Enabled flags take the ALU result, others keep their stored value
    assign flags.z = id_ex.ctrl.wr_z ? alu_zero : flag_q.z;
    assign flags.c = id_ex.ctrl.wr_c ? alu_cout : flag_q.c;
    assign flags.n = id_ex.ctrl.wr_n ? alu_y[`ZMIPS_XLEN-1] : flag_q.n;

    always_ff @(posedge clk)
    begin
        flag_q          <= rst ? '0 : flags;
        ex_mem.alu_rslt <= alu_y;
        ex_mem.st_data  <= fwd_b;                       // Forwarded rt is the store data
        ex_mem.wb_reg   <= id_ex.rd;
        ex_mem.mem_rd   <= !rst && id_ex.ctrl.mem_rd;
        ex_mem.mem_wr   <= !rst && id_ex.ctrl.mem_wr;
        ex_mem.wr_reg   <= !rst && id_ex.ctrl.wr_reg;
    end

endmodule

// File: hw/zmips_control.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_control (
    input  zmips_isa_pkg::instr_t      ir,
    input  zmips_pipe_pkg::id_ex_t     id_ex,
    input  zmips_pipe_pkg::ex_mem_t    ex_mem,
    input  zmips_pipe_pkg::mem_wb_t    mem_wb,
    input  zmips_pipe_pkg::flags_t     flags,
    output zmips_pipe_pkg::id_ctrl_t   ctrl,
    output logic                       stall,
    output logic                       bubble,    // Clears ID/EX control
    output zmips_pipe_pkg::fwd_sel_e   rs_sel,
    output zmips_pipe_pkg::fwd_sel_e   rt_sel,
    output zmips_pipe_pkg::redirect_e  redirect
);

    zmips_isa_pkg::fmt_e  fmt;
    zmips_isa_pkg::cond_e cond;
    logic                 flag, taken;

    assign fmt  = zmips_isa_pkg::fmt_e'(ir.j.op);
    assign cond = zmips_isa_pkg::cond_e'(ir.i.cc);

    // Operand source for EX, newest producer wins
    function automatic zmips_pipe_pkg::fwd_sel_e fwd_src(
        input logic [`ZMIPS_REG_AW-1:0] src,
        input zmips_pipe_pkg::ex_mem_t  mem,
        input zmips_pipe_pkg::mem_wb_t  wb
    );
        if (mem.wr_reg && mem.wb_reg == src)
            return zmips_pipe_pkg::FWD_MEM;
        else if (wb.wr_reg && wb.wb_reg == src)
            return zmips_pipe_pkg::FWD_WB;
        else
            return zmips_pipe_pkg::FWD_REG;
    endfunction

    always_comb
    begin
        ctrl = '0;                                          // Inert unless decoded below
        if (fmt == zmips_isa_pkg::FMT_R)
        begin
            ctrl.alu_op = zmips_isa_pkg::alu_op_e'({ir.r.op[0], ir.r.funct[5:3]});
            ctrl.mem_rd = ir.r.op[3] & ir.r.op[2];          // Load
            ctrl.mem_wr = ir.r.op[3] & ~ir.r.op[2];         // Store
            ctrl.wr_reg = ir.r.op[2];
            ctrl.wr_z   = ir.r.funct[2];
            ctrl.wr_c   = ir.r.funct[1];
            ctrl.wr_n   = ir.r.funct[0];
        end
        else if (fmt == zmips_isa_pkg::FMT_R_LI)
        begin
            ctrl.alu_op  = zmips_isa_pkg::ALU_PASS;         // Immediate into r0
            ctrl.imm_sel = 1'b1;
            ctrl.wr_reg  = 1'b1;
        end
    end

    // Only plain R-format reads registers, so only it can hit a load-use
    assign stall  = id_ex.ctrl.mem_rd && fmt == zmips_isa_pkg::FMT_R
                 && (id_ex.rd == ir.r.rs || id_ex.rd == ir.r.rt);
    assign bubble = stall;

    assign rs_sel = fwd_src(id_ex.rs, ex_mem, mem_wb);
    assign rt_sel = fwd_src(id_ex.rt, ex_mem, mem_wb);

    always_comb
    begin
        case (cond)
            zmips_isa_pkg::COND_Z: flag = flags.z;
            zmips_isa_pkg::COND_C: flag = flags.c;
            default:               flag = flags.n;
        endcase
    end

    // Op bit 1 chooses branch on set or on clear
    assign taken = cond == zmips_isa_pkg::COND_ALWAYS || flag == ir.i.op[1];

    always_comb
    begin
        redirect = zmips_pipe_pkg::REDIR_NONE;
        if (fmt == zmips_isa_pkg::FMT_J)
            redirect = zmips_pipe_pkg::REDIR_JUMP;
        else if (fmt == zmips_isa_pkg::FMT_I && taken)
            redirect = zmips_pipe_pkg::REDIR_BRANCH;
    end

endmodule

// File: hw/zmips_fetch.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_fetch (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  zmips_pipe_pkg::redirect_e redirect,
    input  zmips_isa_pkg::instr_t     i_data,
    output logic [`ZMIPS_XLEN-1:0]    i_addr,
    output zmips_isa_pkg::instr_t     ir,
    output logic [`ZMIPS_XLEN-1:0]    ir_pc     // Address of the instruction in ID
);

    logic [`ZMIPS_XLEN-1:0] pc, pc_next, imm_se, br_target, j_target;
    logic                   flush;

    assign i_addr = pc;

    assign imm_se    = {{(`ZMIPS_XLEN-`ZMIPS_IMM_W){ir.i.imm[`ZMIPS_IMM_W-1]}}, ir.i.imm};
    assign br_target = ir_pc + `ZMIPS_XLEN'(`ZMIPS_PC_STEP)
                     + {imm_se[`ZMIPS_XLEN-3:0], 2'b00};   // Word offset past the branch
    assign j_target  = {ir.j.addr, 2'b00};

    // Any branch or jump in ID kills the slot behind it, taken or not
    assign flush = zmips_isa_pkg::fmt_e'(ir.j.op) inside {zmips_isa_pkg::FMT_I,
                                                          zmips_isa_pkg::FMT_J};

    always_comb
    begin
        case (redirect)
            zmips_pipe_pkg::REDIR_BRANCH: pc_next = br_target;
            zmips_pipe_pkg::REDIR_JUMP:   pc_next = j_target;
            default:                      pc_next = pc + `ZMIPS_XLEN'(`ZMIPS_PC_STEP);
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pc <= `ZMIPS_XLEN'(`ZMIPS_RESET_PC);
            ir <= '0;                       // NOP
        end
        else if (!stall)                    // Load-use stall holds PC and IF/ID
        begin
            pc    <= pc_next;
            ir_pc <= pc;
            ir    <= flush ? '0 : i_data;
        end
    end

endmodule

// File: hw/zmips_mem_wb.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_mem_wb (
    input  logic                    clk,
    input  logic                    rst,
    input  zmips_pipe_pkg::ex_mem_t ex_mem,
    input  logic [`ZMIPS_XLEN-1:0]  d_rdata,    // Same-cycle read data
    output logic [`ZMIPS_XLEN-1:0]  d_addr,
    output logic [`ZMIPS_XLEN-1:0]  d_wdata,
    output logic                    d_rd,
    output logic                    d_wr,
    output zmips_pipe_pkg::mem_wb_t mem_wb,
    output logic [`ZMIPS_XLEN-1:0]  wb_data
);

    // Data port straight off EX/MEM, one-cycle strobes
    assign d_addr  = ex_mem.alu_rslt;
    assign d_wdata = ex_mem.st_data;
    assign d_rd    = ex_mem.mem_rd;
    assign d_wr    = ex_mem.mem_wr;

    always_ff @(posedge clk)
    begin
        mem_wb.mem_data <= d_rdata;
        mem_wb.alu_data <= ex_mem.alu_rslt;
        mem_wb.wb_reg   <= ex_mem.wb_reg;
        mem_wb.mem_rd   <= !rst && ex_mem.mem_rd;
        mem_wb.wr_reg   <= !rst && ex_mem.wr_reg;
    end

    // Loads write back memory data, all else the ALU result
    assign wb_data = mem_wb.mem_rd ? mem_wb.mem_data : mem_wb.alu_data;

endmodule

// File: hw/zmips_regfile.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_regfile (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`ZMIPS_REG_AW-1:0] rs,
    input  logic [`ZMIPS_REG_AW-1:0] rt,
    input  logic [`ZMIPS_REG_AW-1:0] wr_addr,
    input  logic [`ZMIPS_XLEN-1:0]   wr_data,
    input  logic                     wr,
    output logic [`ZMIPS_XLEN-1:0]   rs_val,
    output logic [`ZMIPS_XLEN-1:0]   rt_val
);

    logic [`ZMIPS_XLEN-1:0] regs [2**`ZMIPS_REG_AW];   // r0 is an ordinary register

    always_ff @(posedge clk)
    begin
        if (rst)
            regs <= '{default: '0};
        else if (wr)
            regs[wr_addr] <= wr_data;
    end

    // Write-through so ID sees the value WB is writing this cycle
    assign rs_val = (wr && wr_addr == rs) ? wr_data : regs[rs];
    assign rt_val = (wr && wr_addr == rt) ? wr_data : regs[rt];

endmodule

// File: hw/zmips_top.sv
`timescale 1ns/100ps
`include "zmips_config.svh"

module zmips_top (
    input  logic                   clk,
    input  logic                   rst,
    output logic [`ZMIPS_XLEN-1:0] i_addr,
    input  zmips_isa_pkg::instr_t  i_data,
    output logic [`ZMIPS_XLEN-1:0] d_addr,
    output logic [`ZMIPS_XLEN-1:0] d_wdata,
    input  logic [`ZMIPS_XLEN-1:0] d_rdata,
    output logic                   d_rd,
    output logic                   d_wr
);

    zmips_isa_pkg::instr_t      ir;         // IF/ID instruction
    zmips_pipe_pkg::id_ctrl_t   ctrl;
    zmips_pipe_pkg::id_ex_t     id_ex;
    zmips_pipe_pkg::ex_mem_t    ex_mem;
    zmips_pipe_pkg::mem_wb_t    mem_wb;
    zmips_pipe_pkg::flags_t     flags;      // As seen by the branch in ID
    zmips_pipe_pkg::fwd_sel_e   rs_sel, rt_sel;
    zmips_pipe_pkg::redirect_e  redirect;
    logic                       stall, bubble;
    logic [`ZMIPS_XLEN-1:0]     rs_val, rt_val, wb_data;

    zmips_fetch fetch0 (.clk(clk), .rst(rst), .stall(stall), .redirect(redirect),
        .i_data(i_data), .i_addr(i_addr), .ir(ir), .ir_pc());

    zmips_control control0 (.ir(ir), .id_ex(id_ex), .ex_mem(ex_mem), .mem_wb(mem_wb),
        .flags(flags), .ctrl(ctrl), .stall(stall), .bubble(bubble),
        .rs_sel(rs_sel), .rt_sel(rt_sel), .redirect(redirect));

    // Write port is driven straight from WB
    zmips_regfile regfile0 (.clk(clk), .rst(rst), .rs(ir.r.rs), .rt(ir.r.rt),
        .wr_addr(mem_wb.wb_reg), .wr_data(wb_data), .wr(mem_wb.wr_reg),
        .rs_val(rs_val), .rt_val(rt_val));

    zmips_execute execute0 (.clk(clk), .rst(rst), .ctrl(ctrl), .bubble(bubble),
        .rs_sel(rs_sel), .rt_sel(rt_sel), .ir(ir), .rs_val(rs_val), .rt_val(rt_val),
        .wb_data(wb_data), .id_ex(id_ex), .ex_mem(ex_mem), .flags(flags));

    zmips_mem_wb mem_wb0 (.clk(clk), .rst(rst), .ex_mem(ex_mem), .d_rdata(d_rdata),
        .d_addr(d_addr), .d_wdata(d_wdata), .d_rd(d_rd), .d_wr(d_wr),
        .mem_wb(mem_wb), .wb_data(wb_data));

endmodule

// File: sources.f
+incdir+common
common/zmips_isa_pkg.sv
common/zmips_pipe_pkg.sv
hw/execute/zmips_alu.sv
hw/execute/zmips_execute.sv
hw/zmips_fetch.sv
hw/zmips_control.sv
hw/zmips_regfile.sv
hw/zmips_mem_wb.sv
hw/zmips_top.sv
dv/zmips_tb_clk.sv
dv/zmips_tb.sv
